// ==== noc_pkg.sv ====
package noc_pkg;

    localparam int FLIT_WIDTH     = 64;
    localparam int CHIPID_WIDTH   = 14;
    localparam int XY_WIDTH       = 8;
    localparam int FBITS_WIDTH    = 4;
    localparam int MSG_TYPE_WIDTH = 8;
    localparam int MSG_LEN_WIDTH  = 8;
    localparam int NOC_ADDR_WIDTH = 48;
    localparam int SIZE_WIDTH     = 3;
    localparam int PHY_ADDR_WIDTH = 40; // upper address bits go out as zero

    typedef logic [FLIT_WIDTH-1:0]     flit_t;
    typedef logic [CHIPID_WIDTH-1:0]   chipid_t;
    typedef logic [XY_WIDTH-1:0]       xpos_t;
    typedef logic [XY_WIDTH-1:0]       ypos_t;
    typedef logic [FBITS_WIDTH-1:0]    fbits_t;
    typedef logic [MSG_TYPE_WIDTH-1:0] msg_type_t;
    typedef logic [MSG_LEN_WIDTH-1:0]  msg_len_t;
    typedef logic [NOC_ADDR_WIDTH-1:0] noc_addr_t;

    localparam msg_type_t MSG_NC_LOAD_REQ  = 8'd14;
    localparam msg_type_t MSG_NC_STORE_REQ = 8'd15;

    localparam msg_len_t STORE_MSG_LEN = 8'd3; // two headers plus one data flit
    localparam msg_len_t LOAD_MSG_LEN  = 8'd2;

    localparam logic [SIZE_WIDTH-1:0] DATA_SIZE_8B = 3'b100;

    localparam int NOC_HDR_LEN = 3;
    localparam int QUEUE_DEPTH = 16;

    // bit positions, header 0 and header 2 share the routing fields
    localparam int CHIPID_LSB = 50;
    localparam int XPOS_LSB   = 42;
    localparam int YPOS_LSB   = 34;
    localparam int FBITS_LSB  = 30;
    localparam int LEN_LSB    = 22;
    localparam int TYPE_LSB   = 14;
    localparam int ADDR_LSB   = 16; // header 1
    localparam int SIZE_LSB   = 0;  // header 1

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        DATA
    } seq_state_t;

endpackage

// ==== axi_pkg.sv ====
package axi_pkg;

    localparam int AXI_ADDR_WIDTH = 64;
    localparam int AXI_DATA_WIDTH = 64;
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
    localparam int AXI_RESP_WIDTH = 2;

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t; // byte enables, not forwarded
    typedef logic [AXI_RESP_WIDTH-1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

// ==== req_queue_if.sv ====
`timescale 1ns/100ps

interface req_queue_if;
    import axi_pkg::*;

    logic      offer; // request on the AXI side and room in the queue
    logic      take;  // sequencer accepts the offered request
    logic      avail; // queue holds at least one entry
    axi_addr_t addr;  // head entry
    axi_data_t data;  // head entry, zero for loads
    logic      pop;   // head entry has been sent

    modport queue (
        output offer,
        input  take,
        output avail,
        output addr,
        output data,
        input  pop
    );

    modport seq (
        input  offer,
        output take,
        input  avail,
        input  addr,
        input  data,
        output pop
    );

endinterface

// ==== sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16 // power of two
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             full,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr; // extra bit tells full from empty
    logic [AW:0]      rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr[AW-1:0]]; // head shows without a read
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
        else $error("write into full FIFO");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_en && empty))
        else $error("read from empty FIFO");

endmodule

// ==== store_queue.sv ====
`timescale 1ns/100ps

module store_queue (
    input  logic              clk,
    input  logic              rst,
    input  axi_pkg::axi_addr_t awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic              wvalid,
    output logic              wready,
    req_queue_if.queue        q
);
    import axi_pkg::*;
    import noc_pkg::*;

    localparam int ENTRY_WIDTH = $bits(axi_addr_t) + $bits(axi_data_t);

    logic [ENTRY_WIDTH-1:0] head;
    logic                   full;
    logic                   empty;

    sync_fifo #(
        .WIDTH (ENTRY_WIDTH),
        .DEPTH (QUEUE_DEPTH)
    ) fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (q.take),
        .wr_data ({awaddr, wdata}), // address and data side by side
        .rd_en   (q.pop),
        .rd_data (head),
        .full    (full),
        .empty   (empty)
    );

    assign q.offer = awvalid && wvalid && !full; // both channels needed together
    assign q.avail = !empty;
    assign {q.addr, q.data} = head;

    assign awready = q.take;
    assign wready  = q.take;

endmodule

// ==== load_queue.sv ====
`timescale 1ns/100ps

module load_queue (
    input  logic              clk,
    input  logic              rst,
    input  axi_pkg::axi_addr_t araddr,
    input  logic              arvalid,
    output logic              arready,
    req_queue_if.queue        q
);
    import axi_pkg::*;
    import noc_pkg::*;

    logic full;
    logic empty;

    sync_fifo #(
        .WIDTH ($bits(axi_addr_t)),
        .DEPTH (QUEUE_DEPTH)
    ) fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (q.take),
        .wr_data (araddr),
        .rd_en   (q.pop),
        .rd_data (q.addr),
        .full    (full),
        .empty   (empty)
    );

    assign q.offer = arvalid && !full;
    assign q.avail = !empty;
    assign q.data  = '0; // loads carry no payload
    assign arready = q.take;

endmodule

// ==== flit_sequencer.sv ====
`timescale 1ns/100ps

module flit_sequencer (
    input  logic            clk,
    input  logic            rst,
    req_queue_if.seq        st,
    req_queue_if.seq        ld,
    output logic            noc2_valid,
    output noc_pkg::flit_t  noc2_data,
    input  logic            noc2_ready,
    input  noc_pkg::chipid_t src_chipid,
    input  noc_pkg::xpos_t  src_xpos,
    input  noc_pkg::ypos_t  src_ypos,
    input  noc_pkg::fbits_t src_fbits,
    input  noc_pkg::chipid_t dest_chipid,
    input  noc_pkg::xpos_t  dest_xpos,
    input  noc_pkg::ypos_t  dest_ypos,
    input  noc_pkg::fbits_t dest_fbits
);
    import axi_pkg::*;
    import noc_pkg::*;

    seq_state_t state;
    logic [1:0] flit_cnt;   // header index
    logic       order_full;
    logic       order_empty;
    logic       cur_store;  // head of order FIFO, 1 = store
    logic       order_pop;
    logic       xfer;
    logic       last_hdr;
    axi_addr_t  cur_addr;
    noc_addr_t  msg_addr;
    msg_type_t  msg_type;
    msg_len_t   msg_len;
    flit_t      flit;

    // store wins over a load offered in the same cycle
    assign st.take = st.offer && !order_full;
    assign ld.take = ld.offer && !order_full && !st.take;

    sync_fifo #(
        .WIDTH (1),
        .DEPTH (QUEUE_DEPTH)
    ) order_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (st.take || ld.take),
        .wr_data (st.take),
        .rd_en   (order_pop),
        .rd_data (cur_store),
        .full    (order_full),
        .empty   (order_empty)
    );

    assign xfer      = noc2_valid && noc2_ready;
    assign last_hdr  = (state == HEADER) && (flit_cnt == 2'(NOC_HDR_LEN - 1));
    assign order_pop = xfer && ((last_hdr && !cur_store) || (state == DATA));
    assign st.pop    = order_pop && cur_store;
    assign ld.pop    = order_pop && !cur_store;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            flit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    flit_cnt <= '0;
                    if (!order_empty && (cur_store ? st.avail : ld.avail)) begin
                        state <= HEADER;
                    end
                end
                HEADER: begin
                    if (xfer) begin
                        if (last_hdr) begin
                            state <= cur_store ? DATA : IDLE;
                        end else begin
                            flit_cnt <= flit_cnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (xfer) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign cur_addr = cur_store ? st.addr : ld.addr;
    assign msg_addr = noc_addr_t'(cur_addr[PHY_ADDR_WIDTH-1:0]); // zero extended
    assign msg_type = cur_store ? MSG_NC_STORE_REQ : MSG_NC_LOAD_REQ;
    assign msg_len  = cur_store ? STORE_MSG_LEN : LOAD_MSG_LEN;

    always_comb begin
        flit = '0; // mshrid, options and padding stay zero
        case (state)
            HEADER: begin
                case (flit_cnt)
                    2'd0: begin
                        flit[CHIPID_LSB +: CHIPID_WIDTH]  = dest_chipid;
                        flit[XPOS_LSB +: XY_WIDTH]        = dest_xpos;
                        flit[YPOS_LSB +: XY_WIDTH]        = dest_ypos;
                        flit[FBITS_LSB +: FBITS_WIDTH]    = dest_fbits;
                        flit[LEN_LSB +: MSG_LEN_WIDTH]    = msg_len;
                        flit[TYPE_LSB +: MSG_TYPE_WIDTH]  = msg_type;
                    end
                    2'd1: begin
                        flit[ADDR_LSB +: NOC_ADDR_WIDTH] = msg_addr;
                        flit[SIZE_LSB +: SIZE_WIDTH]     = DATA_SIZE_8B;
                    end
                    default: begin // header 2, return route
                        flit[CHIPID_LSB +: CHIPID_WIDTH] = src_chipid;
                        flit[XPOS_LSB +: XY_WIDTH]       = src_xpos;
                        flit[YPOS_LSB +: XY_WIDTH]       = src_ypos;
                        flit[FBITS_LSB +: FBITS_WIDTH]   = src_fbits;
                    end
                endcase
            end
            DATA:    flit = st.data;
            default: flit = '0;
        endcase
    end

    assign noc2_valid = (state == HEADER) || (state == DATA);
    assign noc2_data  = flit;

    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        noc2_valid && !noc2_ready |=> noc2_valid && $stable(noc2_data))
        else $error("noc2 flit changed while stalled");

    // message ends exactly on the transfer that pops its queue entry
    a_pop_final: assert property (@(posedge clk) disable iff (rst)
        xfer |=> (state == IDLE) == $past(st.pop || ld.pop))
        else $error("queue pop outside a final flit transfer");

endmodule

// ==== response_unpack.sv ====
`timescale 1ns/100ps

module response_unpack (
    input  logic              clk,
    input  logic              rst,
    input  logic              noc3_valid,
    input  noc_pkg::flit_t    noc3_data,
    output logic              noc3_ready,
    output axi_pkg::axi_data_t rdata,
    output logic              rvalid,
    input  logic              rready
);
    import noc_pkg::*;

    typedef enum logic [1:0] {
        RX_HEADER,
        RX_DATA,
        RX_HOLD
    } rx_state_t;

    rx_state_t rx_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state <= RX_HEADER;
        end else begin
            case (rx_state)
                RX_HEADER: begin
                    if (noc3_valid) begin
                        rx_state <= RX_DATA; // header content is dropped
                    end
                end
                RX_DATA: begin
                    if (noc3_valid) begin
                        rx_state <= RX_HOLD;
                    end
                end
                RX_HOLD: begin
                    if (rready) begin
                        rx_state <= RX_HEADER;
                    end
                end
                default: rx_state <= RX_HEADER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && noc3_valid) begin
            rdata <= noc3_data;
        end
    end

    assign noc3_ready = (rx_state != RX_HOLD); // stall while read beat pending
    assign rvalid     = (rx_state == RX_HOLD);

    // only single data flit load responses are supported
    a_resp_len: assert property (@(posedge clk) disable iff (rst)
        (rx_state == RX_HEADER) && noc3_valid |-> noc3_data[LEN_LSB +: MSG_LEN_WIDTH] == 8'd1)
        else $error("noc3 response length is not 1");

endmodule

// ==== axilite_noc_bridge.sv ====
`timescale 1ns/100ps

module axilite_noc_bridge (
    input  logic               clk,
    input  logic               rst,

    input  axi_pkg::axi_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic               wvalid,
    output logic               wready,
    input  axi_pkg::axi_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output axi_pkg::axi_data_t rdata,
    output axi_pkg::axi_resp_t rresp,
    output logic               rvalid,
    input  logic               rready,

    output logic               noc2_valid,
    output noc_pkg::flit_t     noc2_data,
    input  logic               noc2_ready,
    input  logic               noc3_valid,
    input  noc_pkg::flit_t     noc3_data,
    output logic               noc3_ready,

    input  noc_pkg::chipid_t   src_chipid,
    input  noc_pkg::xpos_t     src_xpos,
    input  noc_pkg::ypos_t     src_ypos,
    input  noc_pkg::fbits_t    src_fbits,
    input  noc_pkg::chipid_t   dest_chipid,
    input  noc_pkg::xpos_t     dest_xpos,
    input  noc_pkg::ypos_t     dest_ypos,
    input  noc_pkg::fbits_t    dest_fbits
);
    import axi_pkg::*;

    req_queue_if st_if ();
    req_queue_if ld_if ();

    store_queue store_queue_i (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .q       (st_if.queue)
    );

    load_queue load_queue_i (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .q       (ld_if.queue)
    );

    flit_sequencer flit_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .st          (st_if.seq),
        .ld          (ld_if.seq),
        .noc2_valid  (noc2_valid),
        .noc2_data   (noc2_data),
        .noc2_ready  (noc2_ready),
        .src_chipid  (src_chipid),
        .src_xpos    (src_xpos),
        .src_ypos    (src_ypos),
        .src_fbits   (src_fbits),
        .dest_chipid (dest_chipid),
        .dest_xpos   (dest_xpos),
        .dest_ypos   (dest_ypos),
        .dest_fbits  (dest_fbits)
    );

    response_unpack response_unpack_i (
        .clk        (clk),
        .rst        (rst),
        .noc3_valid (noc3_valid),
        .noc3_data  (noc3_data),
        .noc3_ready (noc3_ready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    assign rresp = RESP_OKAY; // no error path on the NoC side

endmodule

// ==== tb_axilite_noc_bridge.sv ====
`timescale 1ns/100ps

module tb_axilite_noc_bridge;
    import axi_pkg::*;
    import noc_pkg::*;

    localparam int N_REQ       = 200;
    localparam int N_RESP      = 40;
    localparam int CYCLE_LIMIT = N_REQ * 12 + 1600; // up to 12 cycles per request plus margin

    logic      clk = 1'b0;
    logic      rst;
    axi_addr_t awaddr;
    axi_addr_t araddr;
    axi_data_t wdata;
    axi_data_t rdata;
    axi_strb_t wstrb;
    axi_resp_t rresp;
    logic      awvalid, awready, wvalid, wready;
    logic      arvalid, arready, rvalid, rready;
    logic      noc2_valid, noc2_ready, noc3_valid, noc3_ready;
    flit_t     noc2_data;
    flit_t     noc3_data;
    chipid_t   src_chipid, dest_chipid;
    xpos_t     src_xpos, dest_xpos;
    ypos_t     src_ypos, dest_ypos;
    fbits_t    src_fbits, dest_fbits;

    flit_t       exp_q[$];          // flits still to come on noc2
    logic [1:0]  tag_q[$];          // 1 ends a store, 2 ends a load
    flit_t       exp_head;
    logic        exp_avail = 1'b0;
    flit_t       prev_noc2;
    axi_data_t   exp_rdata;
    logic [1:0]  resp_phase = 2'd0; // 0 none, 1 header out, 2 data out
    logic [31:0] lfsr;
    int          errors = 0;
    int          cycles = 0;
    int          sent = 0;
    int          hold_left = 0;
    int          resp_count = 0;
    int          st_pending = 0;
    int          ld_pending = 0;
    int          max_st = 0;
    int          max_ld = 0;
    bit          st_on = 1'b0;
    bit          ld_on = 1'b0;

    axilite_noc_bridge dut_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, error count %0d", cycles, errors);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [63:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic value_error(input string name, input logic [63:0] expv,
                               input logic [63:0] actv);
        errors++;
        $display("** Error %0t: %s expected %h actual %h", $time, name, expv, actv);
    endtask

    task automatic plain_error(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    // builds the message from the header layout, low bits of header 0 are mshrid and options
    task automatic push_msg(input bit is_store, input axi_addr_t addr, input axi_data_t data);
        logic [7:0] len;
        logic [7:0] typ;
        len = is_store ? 8'd3 : 8'd2;
        typ = is_store ? 8'd15 : 8'd14;
        exp_q.push_back({dest_chipid, dest_xpos, dest_ypos, dest_fbits, len, typ, 14'h0});
        exp_q.push_back({8'h0, addr[39:0], 13'h0, 3'b100});
        exp_q.push_back({src_chipid, src_xpos, src_ypos, src_fbits, 30'h0});
        tag_q.push_back(2'd0);
        tag_q.push_back(2'd0);
        tag_q.push_back(is_store ? 2'd0 : 2'd2);
        if (is_store) begin
            exp_q.push_back(data);
            tag_q.push_back(2'd1);
        end
    endtask

    always @(posedge clk) begin : track_flits
        logic [1:0] tag;
        int         st_next;
        int         ld_next;
        tag = 2'd0;
        if (noc2_valid && noc2_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            tag = tag_q.pop_front();
        end
        if (awvalid && awready) push_msg(1'b1, awaddr, wdata);
        if (arvalid && arready) push_msg(1'b0, araddr, '0);
        st_next = st_pending + ((awvalid && awready) ? 1 : 0) - ((tag == 2'd1) ? 1 : 0);
        ld_next = ld_pending + ((arvalid && arready) ? 1 : 0) - ((tag == 2'd2) ? 1 : 0);
        st_pending <= st_next;
        ld_pending <= ld_next;
        if (st_next > max_st) max_st <= st_next;
        if (ld_next > max_ld) max_ld <= ld_next;
        exp_avail <= exp_q.size() != 0;
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
        prev_noc2 <= noc2_data;
    end

    a_flit_expected: assert property (@(posedge clk) disable iff (rst)
        noc2_valid |-> exp_avail)
        else plain_error("noc2 flit sent with no request pending");
    a_flit_value: assert property (@(posedge clk) disable iff (rst)
        noc2_valid && noc2_ready && exp_avail |-> noc2_data == exp_head)
        else value_error("noc2_data", $sampled(exp_head), $sampled(noc2_data));
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        noc2_valid && !noc2_ready |=> noc2_valid && noc2_data == prev_noc2)
        else value_error("noc2_data", $sampled(prev_noc2), $sampled(noc2_data));
    a_store_first: assert property (@(posedge clk) disable iff (rst)
        awvalid && wvalid && arvalid && awready |-> !arready)
        else plain_error("load accepted in the same cycle as a store");
    a_full_block: assert property (@(posedge clk) disable iff (rst)
        st_pending + ld_pending >= QUEUE_DEPTH |-> !awready && !wready && !arready)
        else plain_error("request accepted while the queues were full");
    a_rvalid_rise: assert property (@(posedge clk) disable iff (rst)
        noc3_valid && noc3_ready && resp_phase == 2'd2 |=> rvalid)
        else plain_error("rvalid did not rise after the response data flit");
    a_rdata: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rdata == exp_rdata)
        else value_error("rdata", $sampled(exp_rdata), $sampled(rdata));
    a_rresp: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rresp == RESP_OKAY)
        else value_error("rresp", 64'(RESP_OKAY), 64'($sampled(rresp)));
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else plain_error("rvalid dropped before rready");
    a_noc3_stall: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> !noc3_ready)
        else plain_error("noc3_ready high while a read beat is pending");

    // mode 0 random mix, 1 stores only, 2 loads only
    task automatic drive_cycle(input int n, input int mode);
        logic [63:0] v;
        logic [63:0] a;
        @(posedge clk);
        if (awvalid && awready) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            st_on = 1'b0;
        end
        if (arvalid && arready) begin
            arvalid <= 1'b0;
            ld_on = 1'b0;
        end
        if (!st_on && sent < n && mode != 2) begin
            draw(1, v);
            if (v[0] || mode == 1) begin
                draw(64, a);
                draw(64, v);
                awaddr  <= a;
                wdata   <= v;
                wstrb   <= v[7:0]; // ignored by the bridge
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
                st_on = 1'b1;
                sent++;
            end
        end
        if (!ld_on && sent < n && mode != 1) begin
            draw(1, v);
            if (v[0] || mode == 2) begin
                draw(64, a);
                araddr  <= a;
                arvalid <= 1'b1;
                ld_on = 1'b1;
                sent++;
            end
        end
        if (hold_left > 0) begin
            noc2_ready <= 1'b0;
            hold_left--;
        end else begin
            draw(2, v);
            noc2_ready <= |v[1:0];
        end
        draw(1, v);
        rready <= v[0];
        if (noc3_valid && noc3_ready) begin
            if (resp_phase == 2'd1) begin
                draw(64, v);
                noc3_data  <= v;
                exp_rdata  <= v;
                resp_phase <= 2'd2;
            end else begin
                noc3_valid <= 1'b0;
                resp_phase <= 2'd0;
                resp_count++;
            end
        end else if (resp_phase == 2'd0 && resp_count < N_RESP) begin
            draw(2, v);
            if (&v[1:0]) begin
                draw(56, v);
                noc3_valid <= 1'b1;
                noc3_data  <= {v[55:22], 8'd1, v[21:0]}; // load response, one data flit
                resp_phase <= 2'd1;
            end
        end
    endtask

    task automatic run_requests(input int n, input int mode, input int hold);
        sent = 0;
        hold_left = hold;
        while (sent < n || st_on || ld_on) drive_cycle(n, mode);
    endtask

    task automatic drain_noc2();
        repeat (2) drive_cycle(0, 0);
        while (exp_avail) drive_cycle(0, 0);
    endtask

    initial begin : main
        logic [63:0] v;
        lfsr = 32'h4f74_5350;
        rst = 1'b1;
        {awvalid, wvalid, arvalid, rready, noc2_ready, noc3_valid} = '0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        wstrb = '0;
        noc3_data = '0;
        draw(34, v);
        {src_chipid, src_xpos, src_ypos, src_fbits} = v[33:0];
        draw(34, v);
        {dest_chipid, dest_xpos, dest_ypos, dest_fbits} = v[33:0];
        repeat (4) @(posedge clk);
        assert (noc2_valid === 1'b0 && rvalid === 1'b0 && awready === 1'b0
                && wready === 1'b0 && arready === 1'b0 && noc3_ready === 1'b1)
            else plain_error("outputs not idle after reset");
        rst <= 1'b0;
        run_requests(N_REQ - 40, 0, 0);
        drain_noc2();
        run_requests(20, 1, 60); // noc2 stalled while stores pile up
        drain_noc2();
        run_requests(20, 2, 60);
        drain_noc2();
        repeat (4) drive_cycle(0, 0);
        while (resp_count < N_RESP || rvalid) drive_cycle(0, 0);
        repeat (2) drive_cycle(0, 0);
        if (exp_q.size() != 0) plain_error("expected flits never left on noc2");
        if (max_st < QUEUE_DEPTH) plain_error("store queue never filled under back-pressure");
        if (max_ld < QUEUE_DEPTH) plain_error("load queue never filled under back-pressure");
        $display("error count %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== axilite_noc_bridge.f ====
noc_pkg.sv
axi_pkg.sv
req_queue_if.sv
sync_fifo.sv
store_queue.sv
load_queue.sv
flit_sequencer.sv
response_unpack.sv
axilite_noc_bridge.sv
tb_axilite_noc_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_axilite_noc_bridge \
    -f axilite_noc_bridge.f -o sim_axilite_noc_bridge

out=$(./obj_dir/sim_axilite_noc_bridge)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors"
